/* design/gat_pkg.sv */
package gat_pkg;

  localparam int DATA_WIDTH       = 8;
  localparam int NUM_FEATURE_IN   = 16;
  localparam int NUM_FEATURE_OUT  = 4;
  localparam int COL_IDX_WIDTH    = 4;
  localparam int OUT_IDX_WIDTH    = 2;
  // Source half is 0..3, neighbor half is 4..7
  localparam int A_IDX_WIDTH      = 3;
  // Full sum of 16 signed 8x8 products
  localparam int WH_DATA_WIDTH    = 20;
  localparam int SCORE_WIDTH      = 32;

  localparam int LRELU_SHIFT      = 3;
  localparam int COEF_SHIFT       = 8;

  localparam int COEF_DEPTH       = 16;
  // Depth minus the rows in flight minus one
  localparam int COEF_AFULL_LEVEL = 11;

  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic        [COL_IDX_WIDTH-1:0] col_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_t;
  typedef wh_t         [NUM_FEATURE_OUT-1:0] wh_row_t;
  typedef logic signed [SCORE_WIDTH-1:0]   score_t;
  typedef logic signed [DATA_WIDTH-1:0]    coef_t;

endpackage

/* design/spmm.sv */
`timescale 1ns/10ps

module spmm (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              wgt_we_i,
  input  gat_pkg::col_t                     wgt_row_i,
  input  logic [gat_pkg::OUT_IDX_WIDTH-1:0] wgt_col_i,
  input  gat_pkg::data_t                    wgt_data_i,

  input  logic                              h_vld_i,
  input  gat_pkg::col_t                     h_col_i,
  input  gat_pkg::data_t                    h_val_i,
  input  logic                              h_last_i,
  input  logic                              h_src_i,

  output logic                              wh_vld_o,
  output gat_pkg::wh_row_t                  wh_row_o,
  output logic                              wh_src_o
);

  import gat_pkg::*;

  // Weight matrix, one row per input feature column
  data_t   wgt_q [NUM_FEATURE_IN][NUM_FEATURE_OUT];

  wh_row_t acc_q;
  wh_row_t acc_nxt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_FEATURE_IN; r++) begin
        for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
          wgt_q[r][c] <= '0;
        end
      end
    end else if (wgt_we_i) begin
      wgt_q[wgt_row_i][wgt_col_i] <= wgt_data_i;
    end
  end

  // One sparse entry scales one weight row into all four sums
  always_comb begin
    for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
      acc_nxt[c] = acc_q[c] + h_val_i * wgt_q[h_col_i][c];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (h_vld_i) begin
      // Restart for the next row after its last entry
      acc_q <= h_last_i ? '0 : acc_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_vld_o <= 1'b0;
    end else begin
      wh_vld_o <= h_vld_i & h_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (h_vld_i && h_last_i) begin
      wh_row_o <= acc_nxt;
      wh_src_o <= h_src_i;
    end
  end

endmodule

/* design/dmvm.sv */
`timescale 1ns/10ps

module dmvm (
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic                            a_we_i,
  input  logic [gat_pkg::A_IDX_WIDTH-1:0] a_idx_i,
  input  gat_pkg::data_t                  a_data_i,

  input  logic                            wh_vld_i,
  input  gat_pkg::wh_row_t                wh_row_i,
  input  logic                            wh_src_i,

  output logic                            coef_we_o,
  output gat_pkg::coef_t                  coef_o
);

  import gat_pkg::*;

  data_t  a_q [2*NUM_FEATURE_OUT];

  score_t prod_src_q [NUM_FEATURE_OUT];
  score_t prod_ngh_q [NUM_FEATURE_OUT];
  logic   s1_vld_q;
  logic   s1_src_q;

  score_t src_sum;
  score_t ngh_sum;
  score_t src_score_q;
  score_t ngh_sum_q;
  logic   s2_vld_q;

  score_t raw_score;
  score_t lrelu_score;
  score_t scaled_score;
  coef_t  coef_sat;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2*NUM_FEATURE_OUT; i++) begin
        a_q[i] <= '0;
      end
    end else if (a_we_i) begin
      a_q[a_idx_i] <= a_data_i;
    end
  end

  // Stage 1 products against both halves
  always_ff @(posedge clk) begin
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      prod_src_q[j] <= wh_row_i[j] * a_q[j];
      prod_ngh_q[j] <= wh_row_i[j] * a_q[j+NUM_FEATURE_OUT];
    end
    s1_src_q <= wh_src_i;
  end

  always_comb begin
    src_sum = '0;
    ngh_sum = '0;
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      src_sum = src_sum + prod_src_q[j];
      ngh_sum = ngh_sum + prod_ngh_q[j];
    end
  end

  // Stage 2 latches the source score for the rest of the subgraph
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_score_q <= '0;
    end else if (s1_vld_q && s1_src_q) begin
      src_score_q <= src_sum;
    end
  end

  always_ff @(posedge clk) begin
    ngh_sum_q <= ngh_sum;
  end

  // Stage 3 leaky rectifier, scale and clip to a byte
  always_comb begin
    raw_score    = src_score_q + ngh_sum_q;
    lrelu_score  = raw_score[SCORE_WIDTH-1] ? (raw_score >>> LRELU_SHIFT) : raw_score;
    scaled_score = lrelu_score >>> COEF_SHIFT;
    if (scaled_score[SCORE_WIDTH-1:DATA_WIDTH-1] == '0 ||
        scaled_score[SCORE_WIDTH-1:DATA_WIDTH-1] == '1) begin
      coef_sat = scaled_score[DATA_WIDTH-1:0];
    end else if (scaled_score[SCORE_WIDTH-1]) begin
      coef_sat = {1'b1, {(DATA_WIDTH-1){1'b0}}};
    end else begin
      coef_sat = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    end
  end

  always_ff @(posedge clk) begin
    coef_o <= coef_sat;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld_q  <= 1'b0;
      s2_vld_q  <= 1'b0;
      coef_we_o <= 1'b0;
    end else begin
      s1_vld_q  <= wh_vld_i;
      s2_vld_q  <= s1_vld_q;
      coef_we_o <= s2_vld_q;
    end
  end

endmodule

/* design/coef_fifo.sv */
`timescale 1ns/10ps

module coef_fifo (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr_i,
  input  gat_pkg::coef_t din_i,
  input  logic           rd_i,
  output gat_pkg::coef_t dout_o,
  output logic           empty_o,
  output logic           afull_o
);

  import gat_pkg::*;

  coef_t                            mem [COEF_DEPTH];
  logic [$clog2(COEF_DEPTH)-1:0]    wr_ptr_q;
  logic [$clog2(COEF_DEPTH)-1:0]    rd_ptr_q;
  logic [$clog2(COEF_DEPTH+1)-1:0]  count_q;
  logic                             rd_en;

  assign rd_en = rd_i & ~empty_o;

  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr_q] <= din_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_i, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head shown straight from memory
  assign dout_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign afull_o = (count_q >= COEF_AFULL_LEVEL);

endmodule

/* design/gat_conv1.sv */
`timescale 1ns/10ps

module gat_conv1 (
  input  logic                              clk,
  input  logic                              rst_n,

  input  logic                              wgt_we_i,
  input  gat_pkg::col_t                     wgt_row_i,
  input  logic [gat_pkg::OUT_IDX_WIDTH-1:0] wgt_col_i,
  input  gat_pkg::data_t                    wgt_data_i,

  input  logic                              a_we_i,
  input  logic [gat_pkg::A_IDX_WIDTH-1:0]   a_idx_i,
  input  gat_pkg::data_t                    a_data_i,

  input  logic                              h_vld_i,
  input  gat_pkg::col_t                     h_col_i,
  input  gat_pkg::data_t                    h_val_i,
  input  logic                              h_last_i,
  input  logic                              h_src_i,

  input  logic                              coef_rd_i,
  output gat_pkg::coef_t                    coef_o,
  output logic                              coef_empty_o,
  output logic                              coef_afull_o
);

  import gat_pkg::*;

  logic    wh_vld;
  wh_row_t wh_row;
  logic    wh_src;

  logic    coef_we;
  coef_t   coef_din;

  spmm u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_row_i  (wgt_row_i),
    .wgt_col_i  (wgt_col_i),
    .wgt_data_i (wgt_data_i),
    .h_vld_i    (h_vld_i),
    .h_col_i    (h_col_i),
    .h_val_i    (h_val_i),
    .h_last_i   (h_last_i),
    .h_src_i    (h_src_i),
    .wh_vld_o   (wh_vld),
    .wh_row_o   (wh_row),
    .wh_src_o   (wh_src)
  );

  dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_we_i     (a_we_i),
    .a_idx_i    (a_idx_i),
    .a_data_i   (a_data_i),
    .wh_vld_i   (wh_vld),
    .wh_row_i   (wh_row),
    .wh_src_i   (wh_src),
    .coef_we_o  (coef_we),
    .coef_o     (coef_din)
  );

  coef_fifo u_coef_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_i       (coef_we),
    .din_i      (coef_din),
    .rd_i       (coef_rd_i),
    .dout_o     (coef_o),
    .empty_o    (coef_empty_o),
    .afull_o    (coef_afull_o)
  );

endmodule

/* verif/gat_model.svh */
`ifndef GAT_MODEL_SVH
`define GAT_MODEL_SVH

// One sparse entry added into a transformed feature, wrapped to its width
function automatic longint wh_acc(input longint acc, input int val, input int wgt);
  wh_t w;
  w = wh_t'(acc + longint'(val) * longint'(wgt));
  return longint'(w);
endfunction

// Row times one half of the attention vector
function automatic longint half_dot(input longint row[NUM_FEATURE_OUT],
                                    input int att[2*NUM_FEATURE_OUT], input int base);
  longint sum;
  sum = 0;
  for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
    sum += row[j] * longint'(att[base + j]);
  end
  return sum;
endfunction

// Leaky rectifier, scale, then clip to a signed byte
function automatic int coef_of(input longint raw);
  score_t s;
  longint v;
  longint hi;
  hi = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
  s = score_t'(raw);
  v = longint'(s);
  if (v < 0) begin
    v = v >>> LRELU_SHIFT;
  end
  v = v >>> COEF_SHIFT;
  if (v > hi) begin
    v = hi;
  end else if (v < -hi - 1) begin
    v = -hi - 1;
  end
  return int'(v);
endfunction

`endif

/* verif/gat_conv1_tb.sv */
`timescale 1ns/10ps

module gat_conv1_tb;

  import gat_pkg::*;

  localparam int RD_NONE     = 0;
  localparam int RD_RANDOM   = 1;
  localparam int RD_ALL      = 2;
  localparam int DRAIN_LIMIT = 400;
  // Rough cycle counts of the five tests
  localparam int TOTAL_LEN   = 120 + 200 + 200 + 400 + 250;

  logic                     clk;
  logic                     rst_n;
  logic                     wgt_we_i;
  col_t                     wgt_row_i;
  logic [OUT_IDX_WIDTH-1:0] wgt_col_i;
  data_t                    wgt_data_i;
  logic                     a_we_i;
  logic [A_IDX_WIDTH-1:0]   a_idx_i;
  data_t                    a_data_i;
  logic                     h_vld_i;
  col_t                     h_col_i;
  data_t                    h_val_i;
  logic                     h_last_i;
  logic                     h_src_i;
  logic                     coef_rd_i = 1'b0;
  coef_t                    coef_o;
  logic                     coef_empty_o;
  logic                     coef_afull_o;

  logic        lat_mark;
  logic        saw_afull;
  int          rd_mode;
  logic [31:0] stim_state;
  logic [31:0] rd_state;
  int          w_model [NUM_FEATURE_IN][NUM_FEATURE_OUT];
  int          a_model [2*NUM_FEATURE_OUT];
  longint      src_model;
  int          row_col [8];
  int          row_val [8];
  int          exp_q [$];
  int          exp_head;
  int          exp_cnt;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  // Expected fill level of the FIFO
  logic [3:0]  row_pipe;
  int          fill_cnt;

  `include "gat_model.svh"

  gat_conv1 uut (
    .clk(clk), .rst_n(rst_n),
    .wgt_we_i(wgt_we_i), .wgt_row_i(wgt_row_i), .wgt_col_i(wgt_col_i), .wgt_data_i(wgt_data_i),
    .a_we_i(a_we_i), .a_idx_i(a_idx_i), .a_data_i(a_data_i),
    .h_vld_i(h_vld_i), .h_col_i(h_col_i), .h_val_i(h_val_i),
    .h_last_i(h_last_i), .h_src_i(h_src_i),
    .coef_rd_i(coef_rd_i), .coef_o(coef_o),
    .coef_empty_o(coef_empty_o), .coef_afull_o(coef_afull_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (TOTAL_LEN * 20) @(posedge clk);
    $display("Watchdog expired after %0d cycles", TOTAL_LEN * 20);
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic int next_rand();
    stim_state = xorshift32(stim_state);
    return int'(stim_state & 32'h7fff_ffff);
  endfunction

  function automatic int rand_data();
    data_t d;
    d = data_t'(next_rand());
    return int'(d);
  endfunction

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : 0;
  endfunction

  // Sparse row with some columns repeated
  function automatic int random_row(input int max_len);
    int n;
    n = 1 + next_rand() % max_len;
    for (int i = 0; i < n; i++) begin
      row_col[i] = (i > 0 && next_rand() % 3 == 0) ? row_col[i-1] : next_rand() % NUM_FEATURE_IN;
      row_val[i] = rand_data();
    end
    return n;
  endfunction

  function automatic int fill_row(input int col0, input int step, input int val, input int n);
    for (int i = 0; i < n; i++) begin
      row_col[i] = (col0 + i * step) % NUM_FEATURE_IN;
      row_val[i] = val;
    end
    return n;
  endfunction

  task automatic load_params(input bit rnd, input int wval, input int aval);
    int v;
    for (int r = 0; r < NUM_FEATURE_IN; r++) begin
      for (int c = 0; c < NUM_FEATURE_OUT; c++) begin
        v = rnd ? rand_data() : wval;
        @(posedge clk);
        wgt_we_i   <= 1'b1;
        wgt_row_i  <= col_t'(r);
        wgt_col_i  <= OUT_IDX_WIDTH'(c);
        wgt_data_i <= data_t'(v);
        w_model[r][c] = v;
      end
    end
    for (int i = 0; i < 2 * NUM_FEATURE_OUT; i++) begin
      v = rnd ? rand_data() : aval;
      @(posedge clk);
      wgt_we_i <= 1'b0;
      a_we_i   <= 1'b1;
      a_idx_i  <= A_IDX_WIDTH'(i);
      a_data_i <= data_t'(v);
      a_model[i] = v;
    end
    @(posedge clk);
    a_we_i <= 1'b0;
  endtask

  // Entries go back to back, paused while the FIFO is almost full
  task automatic send_row(input int n, input bit src, input bit mark);
    longint acc [NUM_FEATURE_OUT];
    for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
      acc[j] = 0;
    end
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      while (coef_afull_o) begin
        h_vld_i  <= 1'b0;
        lat_mark <= 1'b0;
        @(posedge clk);
      end
      h_vld_i  <= 1'b1;
      h_col_i  <= col_t'(row_col[i]);
      h_val_i  <= data_t'(row_val[i]);
      h_last_i <= (i == n - 1);
      h_src_i  <= src;
      lat_mark <= mark && (i == n - 1);
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        acc[j] = wh_acc(acc[j], row_val[i], w_model[row_col[i]][j]);
      end
    end
    if (src) begin
      src_model = half_dot(acc, a_model, 0);
    end
    exp_q.push_back(coef_of(src_model + half_dot(acc, a_model, NUM_FEATURE_OUT)));
    refresh_head();
  endtask

  task automatic idle_inputs();
    @(posedge clk);
    h_vld_i  <= 1'b0;
    h_last_i <= 1'b0;
    h_src_i  <= 1'b0;
    lat_mark <= 1'b0;
  endtask

  task automatic drain();
    int k;
    rd_mode <= RD_ALL;
    k = 0;
    while ((exp_cnt != 0 || !coef_empty_o) && k < DRAIN_LIMIT) begin
      @(posedge clk);
      k++;
    end
    // A few reads on the empty FIFO
    repeat (3) @(posedge clk);
    rd_mode <= RD_NONE;
    if (k >= DRAIN_LIMIT) begin
      $display("At %0t the FIFO did not drain, %0d coefficients still expected", $time, exp_cnt);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    if (errors == err0) begin
      tests_passed++;
      $display("%0t %-14s passed", $time, name);
    end else begin
      tests_failed++;
      $display("%0t %-14s %0d errors", $time, name, errors - err0);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && coef_rd_i && !coef_empty_o && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  // A row reaches the FIFO four edges after its accept edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_pipe <= '0;
      fill_cnt <= 0;
    end else begin
      row_pipe <= {row_pipe[2:0], h_vld_i & h_last_i};
      fill_cnt <= fill_cnt + (row_pipe[3] ? 1 : 0) - ((coef_rd_i && fill_cnt > 0) ? 1 : 0);
    end
  end

  always @(posedge clk) begin
    case (rd_mode)
      RD_RANDOM: begin
        rd_state = xorshift32(rd_state);
        coef_rd_i <= rd_state[3];
      end
      RD_ALL:  coef_rd_i <= 1'b1;
      default: coef_rd_i <= 1'b0;
    endcase
  end

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |-> coef_empty_o && !coef_afull_o)
    else begin
      $display("FAIL %0t coef_empty_o expected 1 actual %0b, coef_afull_o expected 0 actual %0b",
               $time, $sampled(coef_empty_o), $sampled(coef_afull_o));
      errors++;
    end

  a_head_value: assert property (@(posedge clk) disable iff (!rst_n)
      (coef_rd_i && !coef_empty_o) |-> (exp_cnt > 0 && coef_o == exp_head))
    else begin
      $display("FAIL %0t coef_o expected %0d actual %0d (%0d expected left)",
               $time, $sampled(exp_head), $sampled(coef_o), $sampled(exp_cnt));
      errors++;
    end

  // Accept edge plus four register stages
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
      lat_mark |-> coef_empty_o [*5] ##1 !coef_empty_o)
    else begin
      $display("At %0t coef_empty_o did not fall 5 cycles after the last entry", $time);
      errors++;
    end

  a_afull_level: assert property (@(posedge clk) disable iff (!rst_n)
      coef_afull_o == (fill_cnt >= COEF_AFULL_LEVEL))
    else begin
      $display("FAIL %0t coef_afull_o expected %0b actual %0b", $time,
               $sampled(fill_cnt) >= COEF_AFULL_LEVEL, $sampled(coef_afull_o));
      errors++;
    end

  a_depth: assert property (@(posedge clk) disable iff (!rst_n)
      uut.u_coef_fifo.count_q <= COEF_DEPTH)
    else begin
      $display("FAIL %0t count_q expected at most %0d actual %0d",
               $time, COEF_DEPTH, $sampled(uut.u_coef_fifo.count_q));
      errors++;
    end

  a_empty_read: assert property (@(posedge clk) disable iff (!rst_n)
      (coef_rd_i && coef_empty_o && !uut.coef_we) |=> coef_empty_o)
    else begin
      $display("At %0t a read of the empty FIFO changed its fill level", $time);
      errors++;
    end

  initial begin
    int n;
    int err0;
    stim_state = 32'd59604;
    rd_state   = xorshift32(32'd59604 ^ 32'h9e37_79b9);
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    src_model = 0;
    refresh_head();
    rd_mode    <= RD_NONE;
    rst_n      <= 1'b0;
    wgt_we_i   <= 1'b0;
    wgt_row_i  <= '0;
    wgt_col_i  <= '0;
    wgt_data_i <= '0;
    a_we_i     <= 1'b0;
    a_idx_i    <= '0;
    a_data_i   <= '0;
    h_vld_i    <= 1'b0;
    h_col_i    <= '0;
    h_val_i    <= '0;
    h_last_i   <= 1'b0;
    h_src_i    <= 1'b0;
    lat_mark   <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // Zero weights first, then a random set
    err0 = errors;
    n = fill_row(3, 0, 77, 1);
    send_row(n, 1'b1, 1'b1);
    idle_inputs();
    drain();
    load_params(1'b1, 0, 0);
    n = random_row(1);
    send_row(n, 1'b1, 1'b1);
    idle_inputs();
    drain();
    report_test("after_reset", err0);

    err0 = errors;
    load_params(1'b1, 0, 0);
    for (int g = 0; g < 2; g++) begin
      for (int r = 0; r < 4 - g; r++) begin
        n = random_row(4);
        send_row(n, r == 0, 1'b0);
      end
    end
    idle_inputs();
    drain();
    report_test("subgraphs", err0);

    err0 = errors;
    load_params(1'b0, 100, 100);
    n = fill_row(0, 5, 100, 3);
    send_row(n, 1'b1, 1'b0);
    send_row(n, 1'b0, 1'b0);
    n = fill_row(2, 0, 1, 1);
    send_row(n, 1'b1, 1'b0);
    n = fill_row(4, 3, -100, 3);
    send_row(n, 1'b0, 1'b0);
    n = fill_row(7, 0, -3, 1);
    send_row(n, 1'b0, 1'b0);
    n = fill_row(9, 0, -1, 1);
    send_row(n, 1'b0, 1'b0);
    idle_inputs();
    drain();
    report_test("rectifier", err0);

    err0 = errors;
    load_params(1'b1, 0, 0);
    rd_mode <= RD_RANDOM;
    for (int g = 0; g < 10; g++) begin
      for (int r = 0; r < 1 + next_rand() % 4; r++) begin
        n = random_row(6);
        send_row(n, r == 0, 1'b0);
      end
    end
    idle_inputs();
    drain();
    report_test("random", err0);

    err0 = errors;
    saw_afull = 1'b0;
    fork
      begin
        for (int r = 0; r < 20; r++) begin
          n = random_row(1);
          send_row(n, r == 0, 1'b0);
        end
        idle_inputs();
      end
      begin
        for (int k = 0; k < 100 && !saw_afull; k++) begin
          @(posedge clk);
          saw_afull = coef_afull_o;
        end
        repeat (8) @(posedge clk);
        rd_mode <= RD_ALL;
      end
    join
    drain();
    if (!saw_afull) begin
      $display("coef_afull_o never rose while reads were held off");
      errors++;
    end
    report_test("backpressure", err0);

    $display("Tests passed %0d, tests with errors %0d, failed checks %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+verif
design/gat_pkg.sv
design/spmm.sv
design/dmvm.sv
design/coef_fifo.sv
design/gat_conv1.sv
verif/gat_conv1_tb.sv

/* Bender.yml */
package:
  name: gat_conv1

sources:
  - files:
      - design/gat_pkg.sv
      - design/spmm.sv
      - design/dmvm.sv
      - design/coef_fifo.sv
      - design/gat_conv1.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/gat_conv1_tb.sv
